/* include/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// 8 KB, two ways, 256 sets of 16-byte lines

// address and instruction bus
`define ICACHE_ADDR_W    32
`define ICACHE_WORD_W    32

// address split, tag | index | byte offset
`define ICACHE_TAG_W     20
`define ICACHE_INDEX_W   8
`define ICACHE_OFFSET_W  4

// associativity
`define ICACHE_NUM_WAYS  2

// replacement LFSR start value, must not be zero
`define ICACHE_LFSR_SEED 8'h07

`endif

/* hw/icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]              addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]              word_t;
    typedef logic [`ICACHE_TAG_W-1:0]               tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]             index_t;
    typedef logic [`ICACHE_OFFSET_W-3:0]            word_sel_t;    // word in line
    typedef logic [$clog2(`ICACHE_NUM_WAYS)-1:0]    way_id_t;
    typedef logic [`ICACHE_WORD_W*(2**(`ICACHE_OFFSET_W-2))-1:0] line_t;

    // lookup address, same for every way
    typedef struct packed {
        index_t    index;
        tag_t      tag;
        word_sel_t word_sel;
    } way_access_t;

    // line write from the refill path
    typedef struct packed {
        index_t index;
        tag_t   tag;
        line_t  line;
    } line_fill_t;

    typedef struct packed {
        logic  valid;
        logic  match;      // stored tag equals request tag
        word_t word;
    } way_result_t;

    typedef struct packed {
        logic  req;
        logic  uncached;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic  beat_ok;    // one word on rdata
        logic  data_ok;    // last word of the transfer
        word_t rdata;
    } mem_resp_t;

    typedef enum logic [1:0] {FREE, LOOK_UP, REFILL, UPDATE} icache_state_t;

    function automatic index_t get_index(addr_t a);
        return a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    endfunction

    function automatic tag_t get_tag(addr_t a);
        return a[`ICACHE_OFFSET_W + `ICACHE_INDEX_W +: `ICACHE_TAG_W];
    endfunction

    function automatic word_sel_t get_word_sel(addr_t a);
        return a[2 +: `ICACHE_OFFSET_W - 2];   // bits 1:0 are the byte in word
    endfunction

endpackage

/* hw/cache_way.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module cache_way import icache_pkg::*; #(
    parameter way_id_t way_id = '0
) (
    input  logic        clk,
    input  logic        reset,
    input  way_access_t access,
    input  line_fill_t  fill,
    input  logic        fill_we,
    input  way_id_t     fill_way,
    output way_result_t result
);

    localparam int num_sets = 2 ** `ICACHE_INDEX_W;

    tag_t                tag_mem  [num_sets];
    line_t               line_mem [num_sets];
    logic [num_sets-1:0] valid_bits;

    tag_t  tag_q;
    line_t line_q;
    logic  valid_q;
    logic  we;
    logic  same_set;     // write hits the set being read

    assign we       = fill_we && (fill_way == way_id);
    assign same_set = we && (fill.index == access.index);

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[fill.index]  <= fill.tag;
            line_mem[fill.index] <= fill.line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[fill.index] <= 1'b1;
        end
    end

    // one-cycle read, write-first on the same set
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_q   <= '0;
            line_q  <= '0;
            valid_q <= 1'b0;
        end else if (same_set) begin
            tag_q   <= fill.tag;
            line_q  <= fill.line;
            valid_q <= 1'b1;
        end else begin
            tag_q   <= tag_mem[access.index];
            line_q  <= line_mem[access.index];
            valid_q <= valid_bits[access.index];
        end
    end

    assign result.valid = valid_q;
    assign result.match = (tag_q == access.tag);
    assign result.word  = line_q[access.word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

/* hw/way_select.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module way_select import icache_pkg::*; (
    input  way_result_t results [`ICACHE_NUM_WAYS],
    output logic        hit,
    output way_id_t     hit_way,
    output word_t       rdata,
    output logic        free_valid,
    output way_id_t     free_way
);

    // tags are unique per set, at most one way can match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        rdata   = '0;
        for (int i = 0; i < `ICACHE_NUM_WAYS; i++) begin
            if (results[i].valid && results[i].match) begin
                hit     = 1'b1;
                hit_way = way_id_t'(i);
                rdata   = results[i].word;
            end
        end
    end

    // an empty way is preferred over a random victim
    always_comb begin
        free_valid = 1'b0;
        free_way   = '0;
        for (int i = 0; i < `ICACHE_NUM_WAYS; i++) begin
            if (!results[i].valid) begin
                free_valid = 1'b1;
                free_way   = way_id_t'(i);    // highest invalid way wins
            end
        end
    end

endmodule

/* hw/icache_request.sv */
`timescale 1ns/100ps

module icache_request import icache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cpu_req,
    input  addr_t       cpu_addr,
    input  logic        cpu_uncached,
    input  logic        accept,
    input  logic        fill_we,
    output addr_t       buf_addr,
    output logic        buf_uncached,
    output way_access_t access
);

    logic take;     // request accepted this cycle

    // a line write keeps the arrays on the refilled set
    assign take = accept && cpu_req && !fill_we;

    always_ff @(posedge clk) begin
        if (take) begin
            buf_addr <= cpu_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_uncached <= 1'b0;
        end else if (take) begin
            buf_uncached <= cpu_uncached;
        end
    end

    // index goes to the arrays one cycle ahead of the compare
    always_comb begin
        if (take) begin
            access.index = get_index(cpu_addr);
        end else begin
            access.index = get_index(buf_addr);    // hold the set while waiting
        end
    end

    // tag and word are used in the lookup cycle, so they come from the buffer
    assign access.tag      = get_tag(buf_addr);
    assign access.word_sel = get_word_sel(buf_addr);

endmodule

/* hw/icache_control.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_control import icache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cpu_req,
    input  addr_t      buf_addr,
    input  logic       buf_uncached,
    input  logic       hit,
    input  way_id_t    hit_way,
    input  word_t      rdata,
    input  logic       free_valid,
    input  way_id_t    free_way,
    input  mem_resp_t  mem_in,
    output logic       accept,
    output line_fill_t fill,
    output logic       fill_we,
    output way_id_t    fill_way,
    output logic       cpu_data_ok,
    output word_t      cpu_rdata,
    output mem_req_t   mem_out
);

    localparam int        words_per_line = 2 ** (`ICACHE_OFFSET_W - 2);
    localparam word_sel_t refill_last    = word_sel_t'(words_per_line - 2);

    icache_state_t state;
    icache_state_t state_next;

    logic [7:0] lfsr;
    logic       lfsr_fb;
    way_id_t    last_hit_way;
    way_id_t    victim;

    // refill buffer, last word comes straight from the bus
    word_t [words_per_line-2:0] beat_buf;
    word_sel_t                  beat_cnt;
    logic                       req_flag;

    logic lookup_hit;
    logic lookup_miss;
    logic resp_done;    // data_ok while in UPDATE

    // uncached requests never hit
    assign lookup_hit  = (state == LOOK_UP) && hit && !buf_uncached;
    assign lookup_miss = (state == LOOK_UP) && !lookup_hit;
    assign resp_done   = (state == UPDATE) && mem_in.data_ok;

    always_comb begin
        state_next = state;
        case (state)
            FREE: begin
                if (cpu_req) state_next = LOOK_UP;
            end
            LOOK_UP: begin
                if (lookup_miss) begin
                    state_next = buf_uncached ? UPDATE : REFILL;
                end else if (!cpu_req) begin
                    state_next = FREE;
                end
            end
            REFILL: begin
                if (mem_in.beat_ok && beat_cnt == refill_last) state_next = UPDATE;
            end
            UPDATE: begin
                // a cached line is read back in LOOK_UP, uncached data is already out
                if (mem_in.data_ok) begin
                    state_next = (buf_uncached && !cpu_req) ? FREE : LOOK_UP;
                end
            end
            default: state_next = FREE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FREE;
        end else begin
            state <= state_next;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= `ICACHE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
        end
    end

    // random pick, skewed by the last way that hit
    assign victim = free_valid ? free_way : (lfsr[$bits(way_id_t)-1:0] ^ last_hit_way);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_flag     <= 1'b0;
            beat_cnt     <= '0;
            fill_way     <= '0;
            last_hit_way <= '0;
        end else begin
            if (lookup_hit) begin
                last_hit_way <= hit_way;
            end
            if (lookup_miss) begin
                req_flag <= 1'b1;
                beat_cnt <= '0;
                fill_way <= victim;
            end else if (mem_in.data_ok) begin
                req_flag <= 1'b0;
            end
            if (state == REFILL && mem_in.beat_ok) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == REFILL && mem_in.beat_ok) begin
            beat_buf[beat_cnt] <= mem_in.rdata;
        end
    end

    assign fill.index = get_index(buf_addr);
    assign fill.tag   = get_tag(buf_addr);
    assign fill.line  = {mem_in.rdata, beat_buf};
    assign fill_we    = resp_done && !buf_uncached;

    // CPU response
    assign cpu_data_ok = lookup_hit || (resp_done && buf_uncached);
    assign cpu_rdata   = (state == UPDATE) ? mem_in.rdata : rdata;
    assign accept      = (state == FREE) || cpu_data_ok;

    // req rises with the miss, falls after data_ok
    assign mem_out.req      = lookup_miss || req_flag;
    assign mem_out.uncached = buf_uncached;
    assign mem_out.addr     = buf_uncached ? buf_addr :
        addr_t'({get_tag(buf_addr), get_index(buf_addr), {`ICACHE_OFFSET_W{1'b0}}});

endmodule

/* hw/icache_top.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_top import icache_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // CPU side
    input  logic      cpu_req,
    input  addr_t     cpu_addr,
    input  logic      cpu_uncached,
    output logic      cpu_addr_ok,
    output logic      cpu_data_ok,
    output word_t     cpu_rdata,

    // memory side
    output mem_req_t  mem_out,
    input  mem_resp_t mem_in
);

    addr_t       buf_addr;
    logic        buf_uncached;
    way_access_t access;
    line_fill_t  fill;
    logic        fill_we;
    way_id_t     fill_way;
    way_result_t results [`ICACHE_NUM_WAYS];
    logic        hit;
    way_id_t     hit_way;
    word_t       rdata;
    logic        free_valid;
    way_id_t     free_way;

    // cpu_addr_ok doubles as the request buffer load enable
    icache_request u_request (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_uncached (cpu_uncached),
        .accept       (cpu_addr_ok),
        .fill_we      (fill_we),
        .buf_addr     (buf_addr),
        .buf_uncached (buf_uncached),
        .access       (access)
    );

    generate
        for (genvar g = 0; g < `ICACHE_NUM_WAYS; g++) begin : g_way
            cache_way #(
                .way_id (way_id_t'(g))
            ) u_way (
                .clk      (clk),
                .reset    (reset),
                .access   (access),
                .fill     (fill),
                .fill_we  (fill_we),
                .fill_way (fill_way),
                .result   (results[g])
            );
        end
    endgenerate

    way_select u_select (
        .results    (results),
        .hit        (hit),
        .hit_way    (hit_way),
        .rdata      (rdata),
        .free_valid (free_valid),
        .free_way   (free_way)
    );

    icache_control u_control (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .buf_addr     (buf_addr),
        .buf_uncached (buf_uncached),
        .hit          (hit),
        .hit_way      (hit_way),
        .rdata        (rdata),
        .free_valid   (free_valid),
        .free_way     (free_way),
        .mem_in       (mem_in),
        .accept       (cpu_addr_ok),
        .fill         (fill),
        .fill_we      (fill_we),
        .fill_way     (fill_way),
        .cpu_data_ok  (cpu_data_ok),
        .cpu_rdata    (cpu_rdata),
        .mem_out      (mem_out)
    );

endmodule

/* tests/icache_asserts.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_asserts import icache_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      cpu_req,
    input addr_t     cpu_addr,
    input logic      cpu_uncached,
    input logic      cpu_addr_ok,
    input logic      cpu_data_ok,
    input mem_req_t  mem_out,
    input mem_resp_t mem_in
);

    logic  accepted;
    logic  busy;        // request between acceptance and cpu_data_ok
    addr_t last_line;   // latest cached refill, nothing can evict it yet
    logic  last_valid;
    logic  line_hit;
    int    fail_count = 0;

    assign accepted = cpu_req && cpu_addr_ok;
    assign line_hit = last_valid && !cpu_uncached &&
        ((cpu_addr >> `ICACHE_OFFSET_W) == (last_line >> `ICACHE_OFFSET_W));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (accepted) begin
            busy <= 1'b1;
        end else if (cpu_data_ok) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_valid <= 1'b0;
            last_line  <= '0;
        end else if (mem_out.req && mem_in.data_ok && !mem_out.uncached) begin
            last_valid <= 1'b1;
            last_line  <= mem_out.addr;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (reset)
        (mem_out.req && !mem_in.data_ok) |=> mem_out.req)
        else begin
            $error("mem_out.req fell before data_ok");
            fail_count++;
        end

    // idle cache has nothing to answer
    no_data_when_free: assert property (@(posedge clk) disable iff (reset)
        cpu_data_ok |-> busy)
        else begin
            $error("cpu_data_ok high with no request outstanding");
            fail_count++;
        end

    hit_next_cycle: assert property (@(posedge clk) disable iff (reset)
        (accepted && line_hit) |=> cpu_data_ok)
        else begin
            $error("cached hit not answered one cycle after acceptance");
            fail_count++;
        end

endmodule

bind icache_top icache_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .cpu_req      (cpu_req),
    .cpu_addr     (cpu_addr),
    .cpu_uncached (cpu_uncached),
    .cpu_addr_ok  (cpu_addr_ok),
    .cpu_data_ok  (cpu_data_ok),
    .mem_out      (mem_out),
    .mem_in       (mem_in)
);

/* tests/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

    localparam int clk_period      = 40;
    localparam int num_rows        = 19;
    localparam int watchdog_cycles = num_rows * 40 + 8;
    localparam logic [1:0] mem_no  = 2'd0;
    localparam logic [1:0] mem_yes = 2'd1;
    localparam logic [1:0] mem_any = 2'd2;    // after a random eviction

    typedef struct packed {
        addr_t      addr;
        logic       uncached;
        logic [1:0] mem_exp;
        logic       hold;       // keep cpu_req up into the next row
    } row_t;

    logic      clk;
    logic      reset;
    logic      cpu_req;
    addr_t     cpu_addr;
    logic      cpu_uncached;
    logic      cpu_addr_ok;
    logic      cpu_data_ok;
    word_t     cpu_rdata;
    mem_req_t  mem_out;
    mem_resp_t mem_in;

    row_t        rows [num_rows];
    int          cycle = 0;
    int          req_count = 0;
    addr_t       req_addr;
    logic        req_uncached;
    int          data_ok_cycle = 0;
    logic [31:0] lfsr_state = 32'h1241;
    int          error_count = 0;
    int          rows_done = 0;
    int          evict_refills = 0;

    icache_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32 22 2 1
    endfunction

    // memory contents
    function automatic word_t mem_word(input addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    task automatic load_table();
        rows[0]  = '{32'h0000_4564, 1'b0, mem_yes, 1'b0};    // cold miss
        rows[1]  = '{32'h0000_456C, 1'b0, mem_no,  1'b0};
        rows[2]  = '{32'h0000_4560, 1'b0, mem_no,  1'b0};
        rows[3]  = '{32'h0001_0230, 1'b0, mem_yes, 1'b0};    // set 0x23, tag A
        rows[4]  = '{32'h0002_0238, 1'b0, mem_yes, 1'b0};    // tag B
        rows[5]  = '{32'h0001_0234, 1'b0, mem_no,  1'b0};
        rows[6]  = '{32'h0002_023C, 1'b0, mem_no,  1'b0};
        rows[7]  = '{32'h0003_0230, 1'b0, mem_yes, 1'b0};    // tag C evicts one
        rows[8]  = '{32'h0001_0230, 1'b0, mem_any, 1'b0};
        rows[9]  = '{32'h0002_0230, 1'b0, mem_any, 1'b0};
        rows[10] = '{32'h0000_8A04, 1'b1, mem_yes, 1'b0};    // uncached
        rows[11] = '{32'h0000_8A04, 1'b1, mem_yes, 1'b0};
        rows[12] = '{32'h0000_4568, 1'b1, mem_yes, 1'b0};    // cached line, read uncached
        rows[13] = '{32'h0000_7F00, 1'b0, mem_yes, 1'b0};
        rows[14] = '{32'h0000_7F00, 1'b0, mem_no,  1'b1};    // four streamed hits
        rows[15] = '{32'h0000_7F04, 1'b0, mem_no,  1'b1};
        rows[16] = '{32'h0000_7F08, 1'b0, mem_no,  1'b1};
        rows[17] = '{32'h0000_7F0C, 1'b0, mem_no,  1'b1};
        rows[18] = '{32'h0000_9008, 1'b0, mem_yes, 1'b0};    // miss right behind a hit
    endtask

    task automatic check_row(input int r, input int acc, input int snap);
        int    delta;
        int    errs_before;
        addr_t exp_addr;
        delta       = req_count - snap;
        errs_before = error_count;
        exp_addr    = rows[r].uncached ? rows[r].addr : {rows[r].addr[31:4], 4'h0};
        if (cpu_rdata !== mem_word(rows[r].addr)) begin
            $display("Mismatch row %0d cpu_rdata: got %h expected %h",
                     r, cpu_rdata, mem_word(rows[r].addr));
            error_count++;
        end
        // a response always opens the door for the next request
        if (cpu_addr_ok !== 1'b1) begin
            $display("Mismatch row %0d cpu_addr_ok: got %h expected %h",
                     r, cpu_addr_ok, 1'b1);
            error_count++;
        end
        if ((rows[r].mem_exp == mem_no && delta != 0) || delta > 1 ||
            (rows[r].mem_exp == mem_yes && delta != 1)) begin
            $display("row %0d: %0d memory requests, not the expected count", r, delta);
            error_count++;
        end
        if (delta == 0 && cycle != acc + 1) begin
            $display("row %0d: hit answered %0d cycles after acceptance", r, cycle - acc);
            error_count++;
        end
        if (delta == 1) begin
            if (req_addr !== exp_addr) begin
                $display("Mismatch row %0d mem_out.addr: got %h expected %h",
                         r, req_addr, exp_addr);
                error_count++;
            end
            if (req_uncached !== rows[r].uncached) begin
                $display("Mismatch row %0d mem_out.uncached: got %h expected %h",
                         r, req_uncached, rows[r].uncached);
                error_count++;
            end
            // uncached answers with data_ok, cached one cycle later
            if (cycle != data_ok_cycle + (rows[r].uncached ? 0 : 1)) begin
                $display("row %0d: answered %0d cycles after data_ok", r, cycle - data_ok_cycle);
                error_count++;
            end
            if (rows[r].mem_exp == mem_any) evict_refills++;
        end
        $display("row %0d addr %h: %s", r, rows[r].addr,
                 (error_count == errs_before) ? "ok" : "failed");
        rows_done++;
    endtask

    // one beat per word, 0 to 3 idle cycles before each
    initial begin : memory_responder
        logic [1:0] idle;
        int         beats;
        addr_t      base;
        mem_in = '0;
        forever begin
            @(negedge clk);
            if (!reset && mem_out.req) begin
                req_count++;
                req_addr     = mem_out.addr;
                req_uncached = mem_out.uncached;
                base         = mem_out.addr;
                beats        = mem_out.uncached ? 1 : 4;
                for (int b = 0; b < beats; b++) begin
                    lfsr_state = lfsr_next(lfsr_state);
                    idle[0]    = lfsr_state[0];
                    lfsr_state = lfsr_next(lfsr_state);
                    idle[1]    = lfsr_state[0];
                    repeat (idle) begin
                        @(posedge clk);
                        #2 mem_in = '0;
                    end
                    @(posedge clk);
                    #2;
                    mem_in.beat_ok = 1'b1;
                    mem_in.data_ok = (b == beats - 1);
                    mem_in.rdata   = mem_word(base + addr_t'(4 * b));
                    if (b == beats - 1) data_ok_cycle = cycle;
                end
                @(posedge clk);
                #2 mem_in = '0;
            end
        end
    end

    initial begin : stimulus
        int   issue_idx;
        logic last_hold;
        int   pending [$];
        int   acc_q [$];
        int   snap_q [$];
        issue_idx    = 0;
        last_hold    = 1'b0;
        reset        = 1'b1;
        cpu_req      = 1'b0;
        cpu_addr     = '0;
        cpu_uncached = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
        while (rows_done < num_rows) begin
            @(posedge clk);
            #2;
            if (issue_idx < num_rows && (pending.size() == 0 || last_hold)) begin
                cpu_req      = 1'b1;
                cpu_addr     = rows[issue_idx].addr;
                cpu_uncached = rows[issue_idx].uncached;
            end else begin
                cpu_req = 1'b0;
            end
            @(negedge clk);
            // response first, a streamed request is accepted in the same cycle
            if (cpu_data_ok) begin
                if (pending.size() == 0) begin
                    $display("cpu_data_ok came with no request outstanding");
                    error_count++;
                end else begin
                    check_row(pending.pop_front(), acc_q.pop_front(), snap_q.pop_front());
                end
            end
            if (cpu_req && cpu_addr_ok) begin
                pending.push_back(issue_idx);
                acc_q.push_back(cycle);
                snap_q.push_back(req_count);
                last_hold = rows[issue_idx].hold;
                issue_idx++;
            end
        end
        if (evict_refills == 0) begin
            $display("third tag in set 0x23 evicted neither older tag");
            error_count++;
        end
        if (UUT.u_asserts.fail_count != 0) begin
            $display("%0d assertion failures", UUT.u_asserts.fail_count);
            error_count += UUT.u_asserts.fail_count;
        end
        $display("%0d rows checked, %0d errors", rows_done, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, only %0d of %0d rows answered", rows_done, num_rows);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hw/icache_pkg.sv
hw/cache_way.sv
hw/way_select.sv
hw/icache_request.sv
hw/icache_control.sv
hw/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module icache_tb -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
